// File: Makefile
TOP = cacheTb
BIN = obj_dir/V$(TOP)
SRCS = cachePkg.sv cacheCtrl.sv cacheWay.sv wayMerge.sv cacheTop.sv cacheTb.sv

.PHONY: all run lint clean

all: run

$(BIN): filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only -Wall --top-module cacheTop \
		cachePkg.sv cacheCtrl.sv cacheWay.sv wayMerge.sv cacheTop.sv

clean:
	rm -rf obj_dir

// File: cacheCases.txt
# columns: case name, byte address (hex), expected word (hex), expected hit (1 = no refill)
# memory word at address a is {a, a} ^ a5a5000000000000
coldMiss       00000068 a5a5006800000068 0
sameLineHi     00000078 a5a5007800000078 1
sameLineLo     00000060 a5a5006000000060 1
secondLine     00000870 a5a5087000000870 0
altFirst       00000060 a5a5006000000060 1
altSecond      00000868 a5a5086800000868 1
altFirstAgain  00000070 a5a5007000000070 1
thirdLine      00001060 a5a5106000001060 0
keptSecond     00000860 a5a5086000000860 1
evictedFirst   00000068 a5a5006800000068 0
thirdKept      00001078 a5a5107800001078 1
evictedSecond  00000878 a5a5087800000878 0
firstKept      00000060 a5a5006000000060 1
burst0         00000870 a5a5087000000870 1
burst1         00000070 a5a5007000000070 1
burst2         00000868 a5a5086800000868 1
burst3         00000078 a5a5007800000078 1
otherSet       00000118 a5a5011800000118 0
burstOther0    00000100 a5a5010000000100 1
burstOther1    00000860 a5a5086000000860 1
burstOther2    00000110 a5a5011000000110 1
thirdReturns   00001060 a5a5106000001060 0
oldFirstGone   00000068 a5a5006800000068 0
thirdStill     00001068 a5a5106800001068 1

// File: cacheCtrl.sv
`default_nettype none

module cacheCtrl #(
  parameter int numWays = 2
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     valid_i,
  input  wire cachePkg::addrT     addr_i,
  output logic                    addr_ok_o,
  output logic                    data_ok_o,
  input  wire                     anyHit_i,
  input  wire [numWays-1:0]       wayValid_i,
  output logic                    lookupEn_o,
  output cachePkg::indexT         lookupIndex_o,
  output cachePkg::tagT           reqTag_o,
  output cachePkg::beatT          beatSel_o,
  output logic                    capture_o,
  output logic [numWays-1:0]      refillWe_o,
  output cachePkg::indexT         refillIndex_o,
  output cachePkg::beatT          refillBeat_o,
  output cachePkg::wordT          refillWord_o,
  output logic                    cacheRdValid_o,
  output cachePkg::addrT          cacheAddr_o,
  input  wire                     rdValid_i,
  input  wire cachePkg::wordT     rdData_i,
  input  wire                     rdLast_i
);

  localparam int WayBits = (numWays > 1) ? $clog2(numWays) : 1;

  typedef enum logic [1:0] {
    StIdle,
    StCompare,
    StRefill,
    StReplay
  } stateT;

  stateT              state;
  stateT              stateNext;
  cachePkg::addrT     reqAddr;
  cachePkg::indexT    reqIndex;
  cachePkg::beatT     beatCnt;
  logic               accept;
  logic               missNow;
  logic               lastBeat;
  logic               freeFound;
  logic [WayBits-1:0] rrPtr;
  logic [WayBits-1:0] victimIdx;
  logic [numWays-1:0] victimSel;

  // new request taken while idle or behind a hit
  assign accept = valid_i && (state == StIdle || (state == StCompare && anyHit_i));
  assign missNow = (state == StCompare) && !anyHit_i;
  assign lastBeat = (state == StRefill) && rdValid_i && rdLast_i;

  always_comb begin
    stateNext = state;
    case (state)
      StIdle: begin
        if (accept) begin
          stateNext = StCompare;
        end
      end
      StCompare: begin
        if (!anyHit_i) begin
          stateNext = StRefill;
        end else if (!valid_i) begin
          stateNext = StIdle;
        end
      end
      StRefill: begin
        if (lastBeat) begin
          stateNext = StReplay;
        end
      end
      default: begin
        stateNext = StCompare;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= StIdle;
      addr_ok_o <= 1'b0;
      data_ok_o <= 1'b0;
    end else begin
      state <= stateNext;
      addr_ok_o <= accept;
      data_ok_o <= (state == StCompare) && anyHit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  assign reqIndex = reqAddr[cachePkg::OffsetWidth +: cachePkg::IndexWidth];
  assign reqTag_o = reqAddr[cachePkg::AddrWidth-1 -: cachePkg::TagWidth];
  assign beatSel_o = reqAddr[cachePkg::OffsetWidth-1 -: $bits(cachePkg::beatT)];

  // replay re-reads the latched set once the line is complete
  assign lookupEn_o = accept || (state == StReplay);
  assign lookupIndex_o = (state == StReplay) ? reqIndex :
                         addr_i[cachePkg::OffsetWidth +: cachePkg::IndexWidth];
  assign capture_o = (state == StCompare);

  // take the lowest empty way or else the round-robin way
  always_comb begin
    freeFound = 1'b0;
    victimIdx = rrPtr;
    for (int w = 0; w < numWays; w++) begin
      if (!freeFound && !wayValid_i[w]) begin
        freeFound = 1'b1;
        victimIdx = WayBits'(w);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rrPtr <= '0;
      victimSel <= '0;
      beatCnt <= '0;
    end else begin
      if (missNow) begin
        victimSel <= numWays'(1) << victimIdx;
        if (!freeFound) begin
          rrPtr <= (rrPtr == WayBits'(numWays - 1)) ? '0 : rrPtr + 1'b1;
        end
      end
      if (state == StRefill && rdValid_i) begin
        beatCnt <= rdLast_i ? '0 : beatCnt + 1'b1;
      end
    end
  end

  assign refillWe_o = (state == StRefill && rdValid_i) ? victimSel : '0;
  assign refillIndex_o = reqIndex;
  assign refillBeat_o = beatCnt;
  assign refillWord_o = rdData_i;

  assign cacheRdValid_o = (state == StRefill);
  assign cacheAddr_o = {reqAddr[cachePkg::AddrWidth-1:cachePkg::OffsetWidth],
                        {cachePkg::OffsetWidth{1'b0}}};

  // each refill beat lands in exactly one way
  refillOneWay: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o && rdValid_i |-> $onehot(refillWe_o));

  // burst request and its address are held through the last beat
  rdValidHeld: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o && !(rdValid_i && rdLast_i) |=> cacheRdValid_o && $stable(cacheAddr_o));

endmodule

`default_nettype wire

// File: cachePkg.sv
`default_nettype none

package cachePkg;

  // address splits into tag, index and offset
  parameter int AddrWidth = 32;
  parameter int Xlen = 64;
  parameter int WordsPerLine = 4;
  parameter int OffsetWidth = 5;
  parameter int IndexWidth = 6;
  parameter int NumSets = 64;
  parameter int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  typedef logic [AddrWidth-1:0] addrT;

  typedef logic [Xlen-1:0] wordT;

  typedef logic [TagWidth-1:0] tagT;

  typedef logic [IndexWidth-1:0] indexT;

  // word position inside a line
  typedef logic [1:0] beatT;

  // word 0 sits in the low 64 bits
  typedef wordT [WordsPerLine-1:0] lineT;

endpackage

`default_nettype wire

// File: cacheTb.sv
`default_nettype none

module cacheTb;

  localparam int CyclesPerCase = 40;
  // 32-byte lines
  localparam int LineBytes = 32;

  logic           clk;
  logic           rst_n;
  logic           valid;
  cachePkg::addrT addr;
  logic           addrOk;
  logic           dataOk;
  cachePkg::wordT rdData;
  logic           cacheRdValid;
  cachePkg::addrT cacheAddr;
  logic           memValid;
  cachePkg::wordT memData;
  logic           memLast;

  // case table and the cases still waiting for data_ok_o
  string          caseName[$];
  cachePkg::addrT caseAddr[$];
  cachePkg::wordT caseWord[$];
  bit             caseHit[$];
  int             pendIdx[$];
  int             refillCount;
  int             doneCount;
  int             cycleCount;
  int             cycleLimit = 100;
  logic           rdValidSeen;

  cacheTop #(
    .numWays(2)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid),
    .addr_i         (addr),
    .addr_ok_o      (addrOk),
    .data_ok_o      (dataOk),
    .rd_data_o      (rdData),
    .cacheRdValid_o (cacheRdValid),
    .cacheAddr_o    (cacheAddr),
    .rdValid_i      (memValid),
    .rdData_i       (memData),
    .rdLast_i       (memLast)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  // memory contents follow from the address alone
  function automatic cachePkg::wordT memWord(input cachePkg::addrT a);
    return {a, a} ^ 64'ha5a5_0000_0000_0000;
  endfunction

  function automatic cachePkg::addrT lineBase(input cachePkg::addrT a);
    return a & ~cachePkg::addrT'(LineBytes - 1);
  endfunction

  task automatic checkWord(input string name, input cachePkg::wordT exp,
                           input cachePkg::wordT act);
    if (act !== exp) begin
      failRun($sformatf("mismatch in %s: read word expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkAddr(input string name, input cachePkg::addrT exp,
                           input cachePkg::addrT act);
    if (act !== exp) begin
      failRun($sformatf("mismatch in %s: refill address expected %h, actual %h",
                        name, exp, act));
    end
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    if (act != exp) begin
      failRun($sformatf("mismatch in %s: refill count expected %0d, actual %0d",
                        name, exp, act));
    end
  endtask

  task automatic readCases();
    int             fd;
    int             n;
    int             h;
    string          line;
    string          nm;
    cachePkg::addrT a;
    cachePkg::wordT w;
    fd = $fopen("cacheCases.txt", "r");
    if (fd == 0) begin
      failRun("could not open cacheCases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %d", nm, a, w, h);
        if (n != 4) begin
          failRun($sformatf("unreadable line in cacheCases.txt: %s", line));
        end
        caseName.push_back(nm);
        caseAddr.push_back(a);
        caseWord.push_back(w);
        caseHit.push_back(h != 0);
      end
    end
    $fclose(fd);
  endtask

  task automatic waitDrained();
    while (pendIdx.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // one burst of four beats with 0 to 2 idle cycles before each
  task automatic serveLine(input cachePkg::addrT base);
    int gap;
    for (int b = 0; b < cachePkg::WordsPerLine; b++) begin
      gap = $urandom % 3;
      repeat (gap) @(negedge clk);
      if (!cacheRdValid) begin
        failRun("burst read request dropped before its last beat");
      end
      memValid = 1'b1;
      memData = memWord(base + cachePkg::addrT'(8 * b));
      memLast = (b == cachePkg::WordsPerLine - 1);
      @(negedge clk);
      memValid = 1'b0;
      memLast = 1'b0;
    end
  endtask

  initial begin : memory
    forever begin
      @(negedge clk);
      if (rst_n && cacheRdValid) begin
        serveLine(cacheAddr);
      end
    end
  end

  // refills and read data belong to the oldest pending case
  initial begin : monitor
    int idx;
    rdValidSeen = 1'b0;
    refillCount = 0;
    doneCount = 0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (cacheRdValid && !rdValidSeen) begin
          if (pendIdx.size() == 0) begin
            failRun("a refill started with no request outstanding");
          end
          idx = pendIdx[0];
          checkAddr(caseName[idx], lineBase(caseAddr[idx]), cacheAddr);
          refillCount++;
        end
        rdValidSeen = cacheRdValid;
        if (dataOk) begin
          if (pendIdx.size() == 0) begin
            failRun("data_ok_o pulsed with no request outstanding");
          end
          idx = pendIdx.pop_front();
          checkWord(caseName[idx], caseWord[idx], rdData);
          checkCount(caseName[idx], caseHit[idx] ? 0 : 1, refillCount);
          refillCount = 0;
          doneCount++;
        end
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount > cycleLimit) begin
        failRun($sformatf("timeout after %0d cycles with %0d of %0d cases done",
                          cycleCount, doneCount, caseName.size()));
      end
    end
  end

  initial begin : stimulus
    int idx;
    rst_n = 1'b0;
    valid = 1'b0;
    addr = '0;
    memValid = 1'b0;
    memData = '0;
    memLast = 1'b0;
    void'($urandom(32'hdcba_86c5));
    readCases();
    if (caseName.size() == 0) begin
      failRun("cacheCases.txt holds no cases");
    end
    cycleLimit = caseName.size() * CyclesPerCase + 100;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (addrOk || dataOk || cacheRdValid) begin
      failRun("addr_ok_o, data_ok_o or cacheRdValid_o high after reset");
    end
    for (idx = 0; idx < caseName.size(); idx++) begin
      // misses start from an empty pipeline while hits follow back to back
      if (!caseHit[idx]) begin
        valid = 1'b0;
        waitDrained();
        @(negedge clk);
      end
      pendIdx.push_back(idx);
      valid = 1'b1;
      addr = caseAddr[idx];
      @(negedge clk);
      while (!addrOk) begin
        @(negedge clk);
      end
    end
    valid = 1'b0;
    waitDrained();
    repeat (2) @(negedge clk);
    if (doneCount == caseName.size() && !dataOk && !cacheRdValid) begin
      $display("Testbench passed");
      $finish;
    end else begin
      failRun($sformatf("run ended with %0d of %0d cases done or the cache still busy",
                        doneCount, caseName.size()));
    end
  end

endmodule

`default_nettype wire

// File: cacheTop.sv
`default_nettype none

module cacheTop #(
  parameter int numWays = 2
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   valid_i,
  input  wire cachePkg::addrT   addr_i,
  output logic                  addr_ok_o,
  output logic                  data_ok_o,
  output cachePkg::wordT        rd_data_o,
  output logic                  cacheRdValid_o,
  output cachePkg::addrT        cacheAddr_o,
  input  wire                   rdValid_i,
  input  wire cachePkg::wordT   rdData_i,
  input  wire                   rdLast_i
);

  logic                         anyHit;
  logic                         lookupEn;
  logic                         capture;
  cachePkg::indexT              lookupIndex;
  cachePkg::indexT              refillIndex;
  cachePkg::tagT                reqTag;
  cachePkg::beatT               beatSel;
  cachePkg::beatT               refillBeat;
  cachePkg::wordT               refillWord;
  logic [numWays-1:0]           refillWe;
  logic [numWays-1:0]           wayHit;
  logic [numWays-1:0]           wayValid;
  cachePkg::lineT [numWays-1:0] wayLines;

  cacheCtrl #(
    .numWays(numWays)
  ) i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .addr_ok_o      (addr_ok_o),
    .data_ok_o      (data_ok_o),
    .anyHit_i       (anyHit),
    .wayValid_i     (wayValid),
    .lookupEn_o     (lookupEn),
    .lookupIndex_o  (lookupIndex),
    .reqTag_o       (reqTag),
    .beatSel_o      (beatSel),
    .capture_o      (capture),
    .refillWe_o     (refillWe),
    .refillIndex_o  (refillIndex),
    .refillBeat_o   (refillBeat),
    .refillWord_o   (refillWord),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .rdValid_i      (rdValid_i),
    .rdData_i       (rdData_i),
    .rdLast_i       (rdLast_i)
  );

  // every way sees the same lookup but only one gets refill writes
  for (genvar w = 0; w < numWays; w++) begin : gWay
    cacheWay i_way (
      .clk           (clk),
      .rst_n         (rst_n),
      .lookupEn_i    (lookupEn),
      .lookupIndex_i (lookupIndex),
      .reqTag_i      (reqTag),
      .refillWe_i    (refillWe[w]),
      .refillIndex_i (refillIndex),
      .refillBeat_i  (refillBeat),
      .refillWord_i  (refillWord),
      .wayHit_o      (wayHit[w]),
      .wayValid_o    (wayValid[w]),
      .wayLine_o     (wayLines[w])
    );
  end

  wayMerge #(
    .numWays(numWays)
  ) i_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .wayHit_i   (wayHit),
    .wayLines_i (wayLines),
    .beatSel_i  (beatSel),
    .capture_i  (capture),
    .anyHit_o   (anyHit),
    .rd_data_o  (rd_data_o)
  );

endmodule

`default_nettype wire

// File: cacheWay.sv
`default_nettype none

module cacheWay (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   lookupEn_i,
  input  wire cachePkg::indexT  lookupIndex_i,
  input  wire cachePkg::tagT    reqTag_i,
  input  wire                   refillWe_i,
  input  wire cachePkg::indexT  refillIndex_i,
  input  wire cachePkg::beatT   refillBeat_i,
  input  wire cachePkg::wordT   refillWord_i,
  output logic                  wayHit_o,
  output logic                  wayValid_o,
  output cachePkg::lineT        wayLine_o
);

  logic [cachePkg::NumSets-1:0] validBits;
  cachePkg::tagT                tagMem [cachePkg::NumSets];
  cachePkg::lineT               lineMem [cachePkg::NumSets];
  cachePkg::tagT                tagQ;
  cachePkg::lineT               lineQ;
  logic                         validQ;

  // set goes valid on its first refill beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
    end else if (refillWe_i) begin
      validBits[refillIndex_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (lookupEn_i) begin
      validQ <= validBits[lookupIndex_i];
    end
  end

  // one word per beat with the tag rewritten each time
  always_ff @(posedge clk) begin
    if (refillWe_i) begin
      lineMem[refillIndex_i][refillBeat_i] <= refillWord_i;
      tagMem[refillIndex_i] <= reqTag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ <= tagMem[lookupIndex_i];
      lineQ <= lineMem[lookupIndex_i];
    end
  end

  // compare against the tag of the request in flight
  assign wayHit_o = validQ && (tagQ == reqTag_i);
  assign wayValid_o = validQ;
  assign wayLine_o = lineQ;

endmodule

`default_nettype wire

// File: filelist.f
cachePkg.sv
cacheCtrl.sv
cacheWay.sv
wayMerge.sv
cacheTop.sv
cacheTb.sv

// File: wayMerge.sv
`default_nettype none

module wayMerge #(
  parameter int numWays = 2
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire [numWays-1:0]                   wayHit_i,
  input  wire cachePkg::lineT [numWays-1:0]   wayLines_i,
  input  wire cachePkg::beatT                 beatSel_i,
  input  wire                                 capture_i,
  output logic                                anyHit_o,
  output cachePkg::wordT                      rd_data_o
);

  cachePkg::lineT hitLine;
  cachePkg::wordT hitWord;

  assign anyHit_o = |wayHit_i;

  // and-or select where only the hitting way contributes
  always_comb begin
    hitLine = '0;
    for (int w = 0; w < numWays; w++) begin
      if (wayHit_i[w]) begin
        hitLine = hitLine | wayLines_i[w];
      end
    end
  end

  assign hitWord = hitLine[beatSel_i];

  // holds until the next hit compare
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_o <= '0;
    end else if (capture_i && anyHit_o) begin
      rd_data_o <= hitWord;
    end
  end

  // a line lives in one way only
  singleHit: assert property (@(posedge clk) disable iff (!rst_n)
    capture_i |-> $onehot0(wayHit_i));

endmodule

`default_nettype wire
